//--- pipe_backend_pkg.sv
/*
  Shared widths, select codes and instruction bundles for the
  load/store pipeline back end (MA, WB and virtual WB stages).
  Every design and testbench file refers to these items with
  pipe_backend_pkg:: scoped names. There is no import anywhere.
*/
package pipe_backend_pkg;

  ////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////
  localparam int WORD_W     = 32;               // Datapath word
  localparam int REG_AW     = 5;                // Register index bits
  localparam int NUM_REGS   = 2 ** REG_AW;      // 32 architectural regs
  localparam int DMEM_DEPTH = 64;               // Data memory words
  localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
  localparam int DMEM_LSB   = 2;                // Byte address to word index

  typedef logic [WORD_W-1:0]  word_t;       // Data or address word
  typedef logic [REG_AW-1:0]  reg_addr_t;   // Register index
  typedef logic [1:0]         wb_sel_t;     // Result select code
  typedef logic [DMEM_AW-1:0] dmem_addr_t;  // Data memory word index

  ////////////////////////////////////////
  // Writeback result select codes
  ////////////////////////////////////////
  localparam wb_sel_t WB_SEL_MEM  = 2'd0;  // Load data
  localparam wb_sel_t WB_SEL_ALU  = 2'd1;  // ALU result
  localparam wb_sel_t WB_SEL_PC   = 2'd2;  // Link pc
  localparam wb_sel_t WB_SEL_ZERO = 2'd3;  // Constant zero

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  // One instruction leaving execute and entering memory access
  // Bubble when both reg_we and mem_wr are low
  typedef struct packed {
    word_t     pc;          // Instruction pc, used for link
    word_t     alu_rslt;    // ALU result and memory byte address
    word_t     store_data;  // Store payload
    reg_addr_t rdst;        // Destination register
    logic      mem_rd;      // Load
    logic      mem_wr;      // Store
    wb_sel_t   wb_sel;      // Result select
    logic      reg_we;      // Register write enable
  } ma_bundle_t;

  // One register write as seen on WB and virtual WB
  typedef struct packed {
    reg_addr_t rdst;    // Destination register
    logic      reg_we;  // Write enable
    word_t     data;    // Write value
  } wb_bundle_t;

endpackage

//--- stage_ma.sv
/*
  Memory access stage.
  Holds the word-addressed data memory. A store is written at the
  edge that ends the MA cycle and a load reads at that same edge,
  so a load sees the contents before a store issued alongside it.
  Also carries the bundle into the MA/WB register.
*/
`timescale 1ns/1ps

module stage_ma (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  pipe_backend_pkg::ma_bundle_t i_ma,         // Bundle from execute
  output pipe_backend_pkg::ma_bundle_t o_ma_wb,      // MA/WB register
  output pipe_backend_pkg::word_t      o_load_data   // Registered load data
);

  pipe_backend_pkg::word_t      dmem [pipe_backend_pkg::DMEM_DEPTH];  // Data memory
  pipe_backend_pkg::dmem_addr_t dmem_addr;   // Word index of access
  pipe_backend_pkg::word_t      load_q;      // Read data register
  pipe_backend_pkg::ma_bundle_t ma_wb_q;     // MA/WB pipeline register

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  // Byte address bits [7:2] pick the word
  assign dmem_addr =
    i_ma.alu_rslt[pipe_backend_pkg::DMEM_LSB +: pipe_backend_pkg::DMEM_AW];

  ////////////////////////////////////////
  // Data memory
  ////////////////////////////////////////

  // Read first, write second
  // Nonblocking assignment gives the old word to a same cycle load
  always_ff @(posedge clk) begin
    if (i_ma.mem_wr) begin
      dmem[dmem_addr] <= i_ma.store_data;  // Store at end of MA
    end
    if (i_ma.mem_rd) begin
      load_q <= dmem[dmem_addr];           // Held until next load
    end
  end

  ////////////////////////////////////////
  // MA/WB register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    ma_wb_q <= i_ma;              // Payload and control
    if (!i_rst_n) begin
      ma_wb_q.reg_we <= 1'b0;     // No register write out of reset
      ma_wb_q.mem_rd <= 1'b0;
      ma_wb_q.mem_wr <= 1'b0;
    end
  end

  assign o_ma_wb     = ma_wb_q;
  assign o_load_data = load_q;   // Lines up with ma_wb_q

endmodule

//--- stage_wb.sv
/*
  Writeback stage.
  Picks the write value by wb_sel among load data, ALU result, pc
  and zero, then passes rdst and the write enable along on o_wb.
  A one-clock-late copy of o_wb is kept as the virtual writeback,
  which drives the register file write port.
*/
`timescale 1ns/1ps

module stage_wb (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  pipe_backend_pkg::ma_bundle_t i_ma_wb,      // From MA/WB register
  input  pipe_backend_pkg::word_t      i_load_data,  // From data memory
  output pipe_backend_pkg::wb_bundle_t o_wb,         // Current writeback
  output pipe_backend_pkg::wb_bundle_t o_vwb         // Writeback one clock late
);

  pipe_backend_pkg::word_t      wb_data;  // Result mux out
  pipe_backend_pkg::wb_bundle_t wb_d;     // Assembled writeback
  pipe_backend_pkg::wb_bundle_t vwb_q;    // Virtual WB register

  // Result select
  always_comb begin
    case (i_ma_wb.wb_sel)
      pipe_backend_pkg::WB_SEL_MEM:  wb_data = i_load_data;
      pipe_backend_pkg::WB_SEL_ALU:  wb_data = i_ma_wb.alu_rslt;
      pipe_backend_pkg::WB_SEL_PC:   wb_data = i_ma_wb.pc;  // Link value
      default:                       wb_data = '0;          // WB_SEL_ZERO
    endcase
  end

  // Control propagation
  always_comb begin
    wb_d.rdst   = i_ma_wb.rdst;
    wb_d.reg_we = i_ma_wb.reg_we;
    wb_d.data   = wb_data;
  end

  // Virtual writeback
  always_ff @(posedge clk) begin
    vwb_q <= wb_d;
    if (!i_rst_n) begin
      vwb_q.reg_we <= 1'b0;  // Keep the register file untouched in reset
    end
  end

  assign o_wb  = wb_d;
  assign o_vwb = vwb_q;

endmodule

//--- reg_file.sv
/*
  Register file, 32 entries of 32 bits.
  One synchronous write port fed by the virtual writeback and two
  combinational read ports for the rs and rt operands.
  Index 0 is never written and always reads zero.
*/
`timescale 1ns/1ps

module reg_file (
  input  logic                         clk,
  input  pipe_backend_pkg::wb_bundle_t i_wr,       // Write port
  input  pipe_backend_pkg::reg_addr_t  i_rs_addr,  // Read port A index
  input  pipe_backend_pkg::reg_addr_t  i_rt_addr,  // Read port B index
  output pipe_backend_pkg::word_t      o_rs_data,
  output pipe_backend_pkg::word_t      o_rt_data
);

  pipe_backend_pkg::word_t regs [pipe_backend_pkg::NUM_REGS];  // Storage, no reset
  logic                    wr_en;  // Qualified write enable

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Register 0 is hardwired, drop writes to it
  assign wr_en = i_wr.reg_we && (i_wr.rdst != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[i_wr.rdst] <= i_wr.data;
    end
  end

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  // No write-through here
  // Same cycle values come from the forwarding unit
  assign o_rs_data = (i_rs_addr == '0) ? '0 : regs[i_rs_addr];
  assign o_rt_data = (i_rt_addr == '0) ? '0 : regs[i_rt_addr];

endmodule

//--- operand_forward.sv
/*
  Operand forwarding unit.
  For each source register returns the newest value in flight.
  Priority is register 0, then WB, then virtual WB, then the
  register file. Purely combinational from the read addresses.
*/
`timescale 1ns/1ps

module operand_forward (
  input  pipe_backend_pkg::reg_addr_t  i_rs_addr,  // Source A index
  input  pipe_backend_pkg::reg_addr_t  i_rt_addr,  // Source B index
  input  pipe_backend_pkg::wb_bundle_t i_wb,       // Youngest write
  input  pipe_backend_pkg::wb_bundle_t i_vwb,      // One clock older
  input  pipe_backend_pkg::word_t      i_rs_rf,    // Register file value A
  input  pipe_backend_pkg::word_t      i_rt_rf,    // Register file value B
  output pipe_backend_pkg::word_t      o_rs_val,
  output pipe_backend_pkg::word_t      o_rt_val
);

  ////////////////////////////////////////
  // Per-operand select
  ////////////////////////////////////////

  // Same priority chain serves both operands
  function automatic pipe_backend_pkg::word_t fwd_pick(
    input pipe_backend_pkg::reg_addr_t  addr,
    input pipe_backend_pkg::wb_bundle_t wb,
    input pipe_backend_pkg::wb_bundle_t vwb,
    input pipe_backend_pkg::word_t      rf_val
  );
    pipe_backend_pkg::word_t val;
    logic                    wb_hit;   // WB writes this register
    logic                    vwb_hit;  // Virtual WB writes this register
    wb_hit  = wb.reg_we  && (wb.rdst  == addr);
    vwb_hit = vwb.reg_we && (vwb.rdst == addr);
    if (addr == '0) begin
      val = '0;           // Hardwired zero wins over any write
    end else if (wb_hit) begin
      val = wb.data;      // Newest
    end else if (vwb_hit) begin
      val = vwb.data;     // Not yet in the register file
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  ////////////////////////////////////////
  // Operand outputs
  ////////////////////////////////////////

  assign o_rs_val = fwd_pick(i_rs_addr, i_wb, i_vwb, i_rs_rf);
  assign o_rt_val = fwd_pick(i_rt_addr, i_wb, i_vwb, i_rt_rf);

endmodule

//--- pipe_backend.sv
/*
  Back end top level of the five-stage load/store pipeline.
  Bundle from execute goes through MA, WB and virtual WB. The
  virtual WB writes the register file and the forwarding unit
  returns the newest rs and rt values. No stalls, no handshake.
*/
`timescale 1ns/1ps

module pipe_backend (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  pipe_backend_pkg::ma_bundle_t i_ma,       // From execute
  input  pipe_backend_pkg::reg_addr_t  i_rs_addr,
  input  pipe_backend_pkg::reg_addr_t  i_rt_addr,
  output pipe_backend_pkg::word_t      o_rs_val,   // Forwarded operand A
  output pipe_backend_pkg::word_t      o_rt_val,   // Forwarded operand B
  output pipe_backend_pkg::wb_bundle_t o_wb,
  output pipe_backend_pkg::wb_bundle_t o_vwb
);

  pipe_backend_pkg::ma_bundle_t ma_wb;      // MA/WB register contents
  pipe_backend_pkg::word_t      load_data;  // Memory read data
  pipe_backend_pkg::word_t      rs_rf;      // Register file read A
  pipe_backend_pkg::word_t      rt_rf;      // Register file read B

  // Memory access
  stage_ma u_stage_ma (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_ma        (i_ma),
    .o_ma_wb     (ma_wb),
    .o_load_data (load_data)
  );

  // Writeback and virtual writeback
  stage_wb u_stage_wb (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_ma_wb     (ma_wb),
    .i_load_data (load_data),
    .o_wb        (o_wb),
    .o_vwb       (o_vwb)
  );

  // Register file, written from virtual WB
  reg_file u_reg_file (
    .clk       (clk),
    .i_wr      (o_vwb),
    .i_rs_addr (i_rs_addr),
    .i_rt_addr (i_rt_addr),
    .o_rs_data (rs_rf),
    .o_rt_data (rt_rf)
  );

  // Operand forwarding
  operand_forward u_operand_forward (
    .i_rs_addr (i_rs_addr),
    .i_rt_addr (i_rt_addr),
    .i_wb      (o_wb),
    .i_vwb     (o_vwb),
    .i_rs_rf   (rs_rf),
    .i_rt_rf   (rt_rf),
    .o_rs_val  (o_rs_val),
    .o_rt_val  (o_rt_val)
  );

endmodule

//--- pipe_backend_asserts.sv
/*
  Concurrent checks on the back end top level.
  Bound to pipe_backend from the bottom of this file. Covers the
  write enables during reset, the hardwired zero register on both
  operand ports and the one-clock delay of the virtual writeback.
*/
`timescale 1ns/1ps

module pipe_backend_asserts (
  input logic                         clk,
  input logic                         i_rst_n,
  input pipe_backend_pkg::reg_addr_t  i_rs_addr,
  input pipe_backend_pkg::reg_addr_t  i_rt_addr,
  input pipe_backend_pkg::word_t      i_rs_val,
  input pipe_backend_pkg::word_t      i_rt_val,
  input pipe_backend_pkg::wb_bundle_t i_wb,    // Top level o_wb
  input pipe_backend_pkg::wb_bundle_t i_vwb    // Top level o_vwb
);

  int unsigned fail_cnt = 0;  // Assertion failures so far

  ////////////////////////////////////////
  // Reset
  ////////////////////////////////////////

  // Both stages cleared once one reset edge has passed
  a_we_low_in_reset : assert property (@(posedge clk)
    (!i_rst_n && !$past(i_rst_n)) |-> (!i_wb.reg_we && !i_vwb.reg_we))
    else begin
      fail_cnt++;
      $error("Write enable high while reset is held");
    end

  ////////////////////////////////////////
  // Register 0
  ////////////////////////////////////////

  a_rs_zero : assert property (@(posedge clk)
    (i_rs_addr == '0) |-> (i_rs_val == '0))
    else begin
      fail_cnt++;
      $error("Operand rs not zero for register 0");
    end

  a_rt_zero : assert property (@(posedge clk)
    (i_rt_addr == '0) |-> (i_rt_val == '0))
    else begin
      fail_cnt++;
      $error("Operand rt not zero for register 0");
    end

  ////////////////////////////////////////
  // Virtual writeback delay
  ////////////////////////////////////////

  a_vwb_we_follows : assert property (@(posedge clk) disable iff (!i_rst_n)
    $past(i_rst_n) |-> (i_vwb.reg_we == $past(i_wb.reg_we)))
    else begin
      fail_cnt++;
      $error("Virtual writeback enable is not last cycle's writeback enable");
    end

  // Payload only matters when the write is live
  a_vwb_payload_follows : assert property (@(posedge clk) disable iff (!i_rst_n)
    ($past(i_rst_n) && i_vwb.reg_we) |->
      ((i_vwb.rdst == $past(i_wb.rdst)) && (i_vwb.data == $past(i_wb.data))))
    else begin
      fail_cnt++;
      $error("Virtual writeback payload is not last cycle's writeback");
    end

endmodule

bind pipe_backend pipe_backend_asserts u_asserts (
  .clk       (clk),
  .i_rst_n   (i_rst_n),
  .i_rs_addr (i_rs_addr),
  .i_rt_addr (i_rt_addr),
  .i_rs_val  (o_rs_val),
  .i_rt_val  (o_rt_val),
  .i_wb      (o_wb),
  .i_vwb     (o_vwb)
);

//--- tb_pipe_backend.sv
/*
  Testbench for the pipeline back end.
  Reads one bundle per cycle from pipe_backend_stimulus.txt, drives
  it on the falling edge and checks o_wb, o_vwb and both operands
  just before the next rising edge. A reference model holds memory,
  registers and a queue of the instructions in flight.
*/
`timescale 1ns/1ps

module tb_pipe_backend;

  localparam int    HALF_PERIOD  = 20;   // 40 ns clock
  localparam int    RESET_CYCLES = 10;
  localparam int    SLACK_CYCLES = 20;   // Margin over the stimulus length
  localparam string STIM_FILE    = "pipe_backend_stimulus.txt";

  logic                         clk = 1'b0;
  logic                         rst_n;
  pipe_backend_pkg::ma_bundle_t ma_in;
  pipe_backend_pkg::reg_addr_t  rs_addr;
  pipe_backend_pkg::reg_addr_t  rt_addr;
  pipe_backend_pkg::word_t      rs_val;
  pipe_backend_pkg::word_t      rt_val;
  pipe_backend_pkg::wb_bundle_t wb;
  pipe_backend_pkg::wb_bundle_t vwb;

  // Stimulus table, one entry per cycle
  string                        tag_q [$];
  pipe_backend_pkg::ma_bundle_t ma_q  [$];
  pipe_backend_pkg::reg_addr_t  rs_q  [$];
  pipe_backend_pkg::reg_addr_t  rt_q  [$];
  pipe_backend_pkg::word_t      ers_q [$];   // Expected rs operand
  pipe_backend_pkg::word_t      ert_q [$];   // Expected rt operand

  // Reference model state
  pipe_backend_pkg::word_t      model_regs [pipe_backend_pkg::NUM_REGS];
  pipe_backend_pkg::word_t      model_mem  [pipe_backend_pkg::DMEM_DEPTH];
  pipe_backend_pkg::word_t      model_load;        // Last load read data
  pipe_backend_pkg::wb_bundle_t inflight [$];      // [0] VWB, [1] WB, [2] MA

  int cycle_cnt   = 0;
  int cycle_limit = SLACK_CYCLES;   // Raised once the file is read

  always #HALF_PERIOD clk = ~clk;

  pipe_backend dut0 (
    .clk       (clk),
    .i_rst_n   (rst_n),
    .i_ma      (ma_in),
    .i_rs_addr (rs_addr),
    .i_rt_addr (rt_addr),
    .o_rs_val  (rs_val),
    .o_rt_val  (rt_val),
    .o_wb      (wb),
    .o_vwb     (vwb)
  );

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("test failed");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  // Target and value only count when the write is live
  task automatic compare_bundle(input string name,
                                input pipe_backend_pkg::wb_bundle_t exp,
                                input pipe_backend_pkg::wb_bundle_t act);
    check_value({name, ".reg_we"}, 32'(exp.reg_we), 32'(act.reg_we));
    if (exp.reg_we) begin
      check_value({name, ".rdst"}, 32'(exp.rdst), 32'(act.rdst));
      check_value({name, ".data"}, exp.data, act.data);
    end
  endtask

  // Bound checker failures seen up to this step
  task automatic check_assertions(input string name);
    if (dut0.u_asserts.fail_cnt != 0) begin
      $display("test failed");
      $fatal(1, "A bound assertion failed before %s", name);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////

  task automatic load_stimulus();
    int                           fd;
    int                           cnt;
    string                        line;
    string                        tag;
    logic [31:0]                  col [12];
    pipe_backend_pkg::ma_bundle_t b;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("test failed");
      $fatal(1, "Could not open the stimulus file %s", STIM_FILE);
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;                             // Blank or column notes
      end
      cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", tag,
                    col[0], col[1], col[2], col[3], col[4], col[5],
                    col[6], col[7], col[8], col[9], col[10], col[11]);
      if (cnt != 13) begin
        $display("test failed");
        $fatal(1, "Stimulus line does not have 13 fields: %s", line);
      end
      b            = '0;
      b.pc         = col[0];
      b.alu_rslt   = col[1];
      b.store_data = col[2];
      b.rdst       = col[3][4:0];
      b.mem_rd     = col[4][0];
      b.mem_wr     = col[5][0];
      b.wb_sel     = col[6][1:0];
      b.reg_we     = col[7][0];
      tag_q.push_back(tag);
      ma_q.push_back(b);
      rs_q.push_back(col[8][4:0]);
      rt_q.push_back(col[9][4:0]);
      ers_q.push_back(col[10]);
      ert_q.push_back(col[11]);
    end
    $fclose(fd);
    if (tag_q.size() == 0) begin
      $display("test failed");
      $fatal(1, "The stimulus file holds no bundles");
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // MA step, the load sees memory before this bundle's store
  function automatic pipe_backend_pkg::wb_bundle_t predict_writeback(
    input pipe_backend_pkg::ma_bundle_t b
  );
    pipe_backend_pkg::wb_bundle_t w;
    pipe_backend_pkg::dmem_addr_t idx;
    idx = b.alu_rslt[7:2];                    // Word index
    if (b.mem_rd) begin
      model_load = model_mem[idx];
    end
    if (b.mem_wr) begin
      model_mem[idx] = b.store_data;
    end
    w.rdst   = b.rdst;
    w.reg_we = b.reg_we;
    case (b.wb_sel)
      2'd0:    w.data = model_load;           // Load data
      2'd1:    w.data = b.alu_rslt;
      2'd2:    w.data = b.pc;                 // Link
      default: w.data = '0;
    endcase
    return w;
  endfunction

  // Newest value of a register as seen from the operand ports
  function automatic pipe_backend_pkg::word_t forward_operand(
    input pipe_backend_pkg::reg_addr_t a
  );
    pipe_backend_pkg::word_t v;
    if (a == '0) begin
      v = '0;
    end else if (inflight[1].reg_we && inflight[1].rdst == a) begin
      v = inflight[1].data;                   // In WB
    end else if (inflight[0].reg_we && inflight[0].rdst == a) begin
      v = inflight[0].data;                   // In VWB
    end else begin
      v = model_regs[a];
    end
    return v;
  endfunction

  // VWB entry lands in the register file at the clock edge
  task automatic retire_oldest();
    pipe_backend_pkg::wb_bundle_t w;
    w = inflight.pop_front();
    if (w.reg_we && w.rdst != '0) begin
      model_regs[w.rdst] = w.data;
    end
  endtask

  ////////////////////////////////////////
  // Run control
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("test failed");
      $fatal(1, "Run did not finish within %0d clock cycles", cycle_limit);
    end
  end

  initial begin
    string                        name;
    pipe_backend_pkg::wb_bundle_t idle;
    rst_n          = 1'b0;
    ma_in          = '0;
    ma_in.alu_rslt = 32'hffffffff;            // Live write that reset holds off
    ma_in.rdst     = 5'd1;
    ma_in.wb_sel   = 2'd1;
    ma_in.reg_we   = 1'b1;
    rs_addr        = '0;
    rt_addr        = '0;
    idle           = '0;
    load_stimulus();
    cycle_limit = tag_q.size() + SLACK_CYCLES;
    inflight.push_back(idle);                 // VWB after reset
    inflight.push_back(idle);                 // WB after reset
    repeat (RESET_CYCLES) @(posedge clk);
    for (int i = 0; i < tag_q.size(); i++) begin
      @(negedge clk);
      rst_n   = 1'b1;
      ma_in   = ma_q[i];
      rs_addr = rs_q[i];
      rt_addr = rt_q[i];
      inflight.push_back(predict_writeback(ma_q[i]));
      #(HALF_PERIOD - 2);                     // Settled, edge not yet reached
      name = $sformatf("%s step %0d", tag_q[i], i);
      check_assertions(name);
      compare_bundle({name, " o_wb"}, inflight[1], wb);
      compare_bundle({name, " o_vwb"}, inflight[0], vwb);
      check_value({name, " o_rs_val"}, ers_q[i], rs_val);
      check_value({name, " o_rt_val"}, ert_q[i], rt_val);
      check_value({name, " o_rs_val model"}, forward_operand(rs_q[i]), rs_val);
      check_value({name, " o_rt_val model"}, forward_operand(rt_q[i]), rt_val);
      @(posedge clk);
      retire_oldest();
    end
    @(negedge clk);                           // Last edge's assertions done
    if (dut0.u_asserts.fail_cnt != 0) begin
      $display("test failed");
      $fatal(1, "A bound assertion failed at the last clock edge");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

//--- pipe_backend_stimulus.txt
# tag pc alu_rslt store_data rdst mem_rd mem_wr wb_sel reg_we rs_addr rt_addr exp_rs exp_rt
# all fields hex, one line per cycle; wb_sel 0 load, 1 alu, 2 pc, 3 zero
reset 00000000 00000000 00000000 00 0 0 0 0 00 00 00000000 00000000
reset 00000000 00000000 00000000 00 0 0 0 0 00 00 00000000 00000000
sel   00000100 11111111 00000000 01 0 0 1 1 00 00 00000000 00000000
sel   00000104 deadbeef 00000000 02 0 0 2 1 01 00 11111111 00000000
sel   00000108 12345678 00000000 03 0 0 3 1 01 02 11111111 00000104
ldst  0000010c 00000040 cafef00d 00 0 1 0 0 01 03 11111111 00000000
ldst  00000110 00000040 00000000 04 1 0 0 1 02 03 00000104 00000000
ldst  00000114 00000040 0badf00d 05 1 1 0 1 04 01 cafef00d 11111111
ldst  00000118 00000040 00000000 06 1 0 0 1 05 04 cafef00d cafef00d
ldst  0000011c 00000044 55aa55aa 00 0 1 0 0 06 05 0badf00d cafef00d
ldst  00000120 00000044 00000000 07 1 0 0 1 06 04 0badf00d cafef00d
ldst  00000124 00000140 00000000 08 1 0 0 1 07 06 55aa55aa 0badf00d
fwd   00000128 00000001 00000000 09 0 0 1 1 08 07 0badf00d 55aa55aa
fwd   0000012c 00000002 00000000 09 0 0 1 1 09 09 00000001 00000001
fwd   00000130 00000003 00000000 09 0 0 1 1 09 09 00000002 00000002
fwd   00000000 00000000 00000000 00 0 0 0 0 09 09 00000003 00000003
fwd   00000000 00000000 00000000 00 0 0 0 0 09 08 00000003 0badf00d
fwd   00000000 00000000 00000000 00 0 0 0 0 09 01 00000003 11111111
fwd   00000134 ffffffff 00000000 09 0 0 1 0 09 02 00000003 00000104
fwd   00000000 00000000 00000000 00 0 0 0 0 09 09 00000003 00000003
r0    00000138 77777777 00000000 00 0 0 1 1 09 00 00000003 00000000
r0    0000013c 88888888 00000000 00 0 0 1 1 00 00 00000000 00000000
r0    00000000 00000000 00000000 00 0 0 0 0 00 00 00000000 00000000
vwb   00000200 00000000 00000000 0a 0 0 2 1 03 00 00000000 00000000
vwb   00000204 00000044 00000000 0b 1 0 0 1 0a 00 00000200 00000000
vwb   00000208 00000048 13579bdf 00 0 1 0 0 0b 0a 55aa55aa 00000200
vwb   0000020c 00000048 00000000 0c 1 0 0 1 0b 0a 55aa55aa 00000200
vwb   00000000 00000000 00000000 00 0 0 0 0 0c 0b 13579bdf 55aa55aa
vwb   00000000 00000000 00000000 00 0 0 0 0 0c 05 13579bdf cafef00d
vwb   00000000 00000000 00000000 00 0 0 0 0 0c 07 13579bdf 55aa55aa

//--- pipe_backend.f
pipe_backend_pkg.sv
stage_ma.sv
stage_wb.sv
reg_file.sv
operand_forward.sv
pipe_backend.sv
pipe_backend_asserts.sv
tb_pipe_backend.sv

//--- Makefile
# Verilator build and run for the pipeline back end

VERILATOR ?= verilator
TOP       := tb_pipe_backend
FILELIST  := pipe_backend.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
